/* source/dispatch_cfg_pkg.sv */
`default_nettype none

package dispatch_cfg_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  // cpus in the system
  localparam int CPU_QUANTITY = 4;

  // width of a cpu number and of the active and inactive counters
  localparam int CPU_NUM_W = 8;

  // index word seen by the cpus
  localparam int CPU_INDEX_W = 16;

  // address and data words
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // cpu number or cpu count
  typedef logic [CPU_NUM_W-1:0] cpu_num_t;

  // top bit is the active flag, next one the inactive flag
  // cpu number sits in the low CPU_NUM_W bits
  typedef logic [CPU_INDEX_W-1:0] cpu_index_t;

endpackage

`default_nettype wire

/* source/dispatch_proto_pkg.sv */
`default_nettype none

package dispatch_proto_pkg;

  // index flags are built on the index word type
  import dispatch_cfg_pkg::*;

  // messages from the cpu side
  localparam int CPU_MSG_W = 8;

  typedef logic [CPU_MSG_W-1:0] cpu_msg_t;

  // cpu came up and takes a process
  localparam cpu_msg_t CPU_R_START = 8'd1;
  // cpu dropped back to idle
  localparam cpu_msg_t CPU_R_END = 8'd2;

  // index flags, or-ed with the cpu number
  localparam cpu_index_t CPU_ACTIVE    = cpu_index_t'(1) << (CPU_INDEX_W - 1);
  localparam cpu_index_t CPU_NONACTIVE = cpu_index_t'(1) << (CPU_INDEX_W - 2);

  // dispatcher states
  typedef enum logic [2:0] {
    // pick the next cpu or hand out the bus
    CPU_LOOP,
    // wait for a message or a memory request
    CPU_CMD,
    // one memory operation in flight
    MEM_WORK,
    // single cycle to drop done levels
    MEM_FINISH,
    // external master owns the bus
    EXT_BUS
  } sched_state_t;

endpackage

`default_nettype wire

/* source/mem_req_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_req_if import dispatch_cfg_pkg::*; ();

  // request side, one cycle pulses
  logic  rd_start;
  logic  wr_start;
  addr_t addr;
  data_t wdata;

  // completion side, one cycle pulses
  logic  ack;
  logic  halted;
  // response word, valid with ack
  addr_t rsp_addr;
  data_t rsp_data;

  // dispatcher end
  modport sched (
    output rd_start, wr_start, addr, wdata,
    input  ack, halted, rsp_addr, rsp_data
  );

  // external memory end
  modport bridge (
    input  rd_start, wr_start, addr, wdata,
    output ack, halted, rsp_addr, rsp_data
  );

endinterface

`default_nettype wire

/* source/cpu_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_scheduler import dispatch_cfg_pkg::*; import dispatch_proto_pkg::*; (
  input  wire        clk,
  input  wire        ext_rst_e,
  input  wire        ext_cpu_e,
  input  wire        read_q,
  input  wire        write_q,
  input  wire        ext_bus_q,
  input  cpu_msg_t   cpu_msg_in,
  input  addr_t      addr_in,
  input  data_t      data_in,
  input  addr_t      next_proc_addr,
  input  data_t      next_proc_data,
  output logic       ext_cpu_q,
  output cpu_index_t ext_cpu_index,
  output addr_t      addr_out,
  output data_t      data_out,
  output logic       read_dn,
  output logic       write_dn,
  output logic       bus_busy,
  output logic       ext_bus_allow,
  mem_req_if.sched   mem
);

  sched_state_t state;

  // cpu accounting
  cpu_num_t active_cnt;
  cpu_num_t inactive_cnt;
  cpu_num_t cpu_num;
  // set after a cpu from the idle pool got the last dispatch
  logic     restarted;

  // kind of operation in flight, 1 for read
  logic     op_rd;

  cpu_num_t num_plus_1;
  cpu_num_t next_num;
  logic     mem_req;

  // round robin over the active cpus
  assign num_plus_1 = cpu_num + cpu_num_t'(1);
  assign next_num   = (num_plus_1 < active_cnt) ? num_plus_1 : '0;

  // memory request taken in CPU_CMD
  assign mem_req = (state == CPU_CMD) && (read_q || write_q);

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      state         <= CPU_LOOP;
      active_cnt    <= '0;
      inactive_cnt  <= cpu_num_t'(CPU_QUANTITY);
      cpu_num       <= '0;
      restarted     <= 1'b0;
      op_rd         <= 1'b0;
      ext_cpu_q     <= 1'b0;
      ext_cpu_index <= '0;
      addr_out      <= '0;
      data_out      <= '0;
      read_dn       <= 1'b0;
      write_dn      <= 1'b0;
      bus_busy      <= 1'b0;
      ext_bus_allow <= 1'b0;
      mem.rd_start  <= 1'b0;
      mem.wr_start  <= 1'b0;
    end else begin
      // strobes and data words fall back every cycle
      ext_cpu_q    <= 1'b0;
      read_dn      <= 1'b0;
      write_dn     <= 1'b0;
      addr_out     <= '0;
      data_out     <= '0;
      mem.rd_start <= 1'b0;
      mem.wr_start <= 1'b0;

      case (state)
        CPU_LOOP: begin
          if (ext_bus_q) begin
            state <= EXT_BUS;
          end else if (!ext_cpu_e) begin
            // idle cpu first, then the next active one
            if (inactive_cnt > 0 && !restarted) begin
              ext_cpu_index <= CPU_NONACTIVE;
              restarted     <= 1'b1;
            end else begin
              cpu_num       <= next_num;
              ext_cpu_index <= CPU_ACTIVE | cpu_index_t'(next_num);
              restarted     <= 1'b0;
            end
            addr_out  <= next_proc_addr;
            data_out  <= next_proc_data;
            ext_cpu_q <= 1'b1;
            state     <= CPU_CMD;
          end
        end

        CPU_CMD: begin
          // read wins over write
          if (read_q) begin
            mem.rd_start <= 1'b1;
            op_rd        <= 1'b1;
            state        <= MEM_WORK;
          end else if (write_q) begin
            mem.wr_start <= 1'b1;
            op_rd        <= 1'b0;
            state        <= MEM_WORK;
          end else if (ext_cpu_e) begin
            case (cpu_msg_in)
              CPU_R_START: begin
                inactive_cnt <= inactive_cnt - cpu_num_t'(1);
                active_cnt   <= active_cnt + cpu_num_t'(1);
                cpu_num      <= num_plus_1;
              end
              CPU_R_END: begin
                active_cnt   <= active_cnt - cpu_num_t'(1);
                inactive_cnt <= inactive_cnt + cpu_num_t'(1);
              end
              default: begin
                // nothing to count
              end
            endcase
            state <= CPU_LOOP;
          end
        end

        MEM_WORK: begin
          if (mem.ack) begin
            // response goes out with the done strobe
            addr_out <= mem.rsp_addr;
            data_out <= mem.rsp_data;
            read_dn  <= op_rd;
            write_dn <= !op_rd;
            bus_busy <= 1'b0;
            state    <= MEM_FINISH;
          end else if (mem.halted) begin
            // aborted, no done strobe
            bus_busy <= 1'b0;
            state    <= MEM_FINISH;
          end else begin
            bus_busy <= 1'b1;
          end
        end

        MEM_FINISH: begin
          state <= CPU_LOOP;
        end

        EXT_BUS: begin
          ext_bus_allow <= ext_bus_q;
          if (!ext_bus_q) begin
            state <= CPU_LOOP;
          end
        end

        default: begin
          state <= CPU_LOOP;
        end
      endcase
    end
  end

  // request words for the bridge
  always_ff @(posedge clk) begin
    if (mem_req) begin
      mem.addr  <= addr_in;
      mem.wdata <= data_in;
    end
  end

endmodule

`default_nettype wire

/* source/mem_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_bridge import dispatch_cfg_pkg::*; (
  input  wire       clk,
  input  wire       ext_rst_e,
  input  wire       ext_read_dn,
  input  wire       ext_write_dn,
  input  wire       rw_halt_in,
  input  wire       ext_rw_halt_in,
  input  addr_t     ext_mem_addr_in,
  input  data_t     ext_mem_data_in,
  output logic      ext_read_q,
  output logic      ext_write_q,
  output addr_t     ext_mem_addr_out,
  output data_t     ext_mem_data_out,
  output logic      rw_halt_out,
  output logic      ext_rw_halt_out,
  mem_req_if.bridge mem
);

  // operation in flight
  logic  pend_rd;
  logic  pend_wr;
  logic  pending;

  // latched request words
  addr_t addr_q;
  data_t data_q;

  logic  start_hit;
  logic  done_hit;

  assign pending = pend_rd | pend_wr;

  // new request only when idle
  assign start_hit = !pending && (mem.rd_start || mem.wr_start);

  // halts take priority over the done inputs
  assign done_hit = pending && !rw_halt_in && !ext_rw_halt_in &&
                    ((pend_rd && ext_read_dn) || (pend_wr && ext_write_dn));

  // address held for the whole operation, write data only on writes
  assign ext_mem_addr_out = pending ? addr_q : '0;
  assign ext_mem_data_out = pend_wr ? data_q : '0;

  always_ff @(posedge clk) begin
    if (ext_rst_e) begin
      pend_rd         <= 1'b0;
      pend_wr         <= 1'b0;
      ext_read_q      <= 1'b0;
      ext_write_q     <= 1'b0;
      rw_halt_out     <= 1'b0;
      ext_rw_halt_out <= 1'b0;
      mem.ack         <= 1'b0;
      mem.halted      <= 1'b0;
    end else begin
      ext_read_q      <= 1'b0;
      ext_write_q     <= 1'b0;
      rw_halt_out     <= 1'b0;
      ext_rw_halt_out <= 1'b0;
      mem.ack         <= 1'b0;
      mem.halted      <= 1'b0;

      if (pending) begin
        if (rw_halt_in) begin
          // cpu side abort, tell memory
          pend_rd         <= 1'b0;
          pend_wr         <= 1'b0;
          ext_rw_halt_out <= 1'b1;
          mem.halted      <= 1'b1;
        end else if (ext_rw_halt_in) begin
          // memory side abort, tell the cpu
          pend_rd     <= 1'b0;
          pend_wr     <= 1'b0;
          rw_halt_out <= 1'b1;
          mem.halted  <= 1'b1;
        end else if (done_hit) begin
          pend_rd <= 1'b0;
          pend_wr <= 1'b0;
          mem.ack <= 1'b1;
        end
      end else if (mem.rd_start) begin
        pend_rd    <= 1'b1;
        ext_read_q <= 1'b1;
      end else if (mem.wr_start) begin
        pend_wr     <= 1'b1;
        ext_write_q <= 1'b1;
      end
    end
  end

  // payload capture
  always_ff @(posedge clk) begin
    if (start_hit) begin
      addr_q <= mem.addr;
      data_q <= mem.wdata;
    end
    // response taken in the done cycle
    if (done_hit) begin
      mem.rsp_addr <= ext_mem_addr_in;
      mem.rsp_data <= ext_mem_data_in;
    end
  end

endmodule

`default_nettype wire

/* source/cpu_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_dispatcher import dispatch_cfg_pkg::*; import dispatch_proto_pkg::*; (
  input  wire        clk,
  input  wire        ext_rst_e,
  // cpu side
  input  wire        ext_cpu_e,
  input  wire        read_q,
  input  wire        write_q,
  input  cpu_msg_t   cpu_msg_in,
  input  addr_t      addr_in,
  input  data_t      data_in,
  input  addr_t      next_proc_addr,
  input  data_t      next_proc_data,
  input  wire        rw_halt_in,
  output logic       ext_cpu_q,
  output cpu_index_t ext_cpu_index,
  output addr_t      addr_out,
  output data_t      data_out,
  output logic       read_dn,
  output logic       write_dn,
  output logic       bus_busy,
  output logic       rw_halt_out,
  // external bus master
  input  wire        ext_bus_q,
  output logic       ext_bus_allow,
  // external memory side
  input  wire        ext_read_dn,
  input  wire        ext_write_dn,
  input  wire        ext_rw_halt_in,
  input  addr_t      ext_mem_addr_in,
  input  data_t      ext_mem_data_in,
  output logic       ext_read_q,
  output logic       ext_write_q,
  output addr_t      ext_mem_addr_out,
  output data_t      ext_mem_data_out,
  output logic       ext_rw_halt_out
);

  // scheduler to bridge link
  mem_req_if mem ();

  cpu_scheduler sched_inst (
    .clk            (clk),
    .ext_rst_e      (ext_rst_e),
    .ext_cpu_e      (ext_cpu_e),
    .read_q         (read_q),
    .write_q        (write_q),
    .ext_bus_q      (ext_bus_q),
    .cpu_msg_in     (cpu_msg_in),
    .addr_in        (addr_in),
    .data_in        (data_in),
    .next_proc_addr (next_proc_addr),
    .next_proc_data (next_proc_data),
    .ext_cpu_q      (ext_cpu_q),
    .ext_cpu_index  (ext_cpu_index),
    .addr_out       (addr_out),
    .data_out       (data_out),
    .read_dn        (read_dn),
    .write_dn       (write_dn),
    .bus_busy       (bus_busy),
    .ext_bus_allow  (ext_bus_allow),
    .mem            (mem.sched)
  );

  mem_bridge bridge_inst (
    .clk              (clk),
    .ext_rst_e        (ext_rst_e),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .rw_halt_in       (rw_halt_in),
    .ext_rw_halt_in   (ext_rw_halt_in),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .rw_halt_out      (rw_halt_out),
    .ext_rw_halt_out  (ext_rw_halt_out),
    .mem              (mem.bridge)
  );

endmodule

`default_nettype wire

/* testbench/tb_cpu_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_dispatcher import dispatch_cfg_pkg::*; import dispatch_proto_pkg::*; ();

  // limit far above the length of the whole run
  localparam int TIMEOUT_CYC = 4000;
  // message code that is neither start nor end
  localparam cpu_msg_t OTHER_MSG = 8'h3c;

  logic       clk;
  logic       ext_rst_e;
  logic       ext_cpu_e;
  logic       read_q;
  logic       write_q;
  cpu_msg_t   cpu_msg_in;
  addr_t      addr_in;
  data_t      data_in;
  addr_t      next_proc_addr;
  data_t      next_proc_data;
  logic       rw_halt_in;
  logic       ext_cpu_q;
  cpu_index_t ext_cpu_index;
  addr_t      addr_out;
  data_t      data_out;
  logic       read_dn;
  logic       write_dn;
  logic       bus_busy;
  logic       rw_halt_out;
  logic       ext_bus_q;
  logic       ext_bus_allow;
  logic       ext_read_dn;
  logic       ext_write_dn;
  logic       ext_rw_halt_in;
  addr_t      ext_mem_addr_in;
  data_t      ext_mem_data_in;
  logic       ext_read_q;
  logic       ext_write_q;
  addr_t      ext_mem_addr_out;
  data_t      ext_mem_data_out;
  logic       ext_rw_halt_out;

  integer     seed = 32'h845c_28e5;
  int         cycle_cnt;
  // memory model keeps quiet while set
  logic       mem_hold;

  // reference copy of the cpu accounting
  cpu_num_t   active_ref;
  cpu_num_t   inactive_ref;
  cpu_num_t   num_ref;
  logic       restarted_ref;

  cpu_dispatcher cpu_dispatcher_inst (
    .clk              (clk),
    .ext_rst_e        (ext_rst_e),
    .ext_cpu_e        (ext_cpu_e),
    .read_q           (read_q),
    .write_q          (write_q),
    .cpu_msg_in       (cpu_msg_in),
    .addr_in          (addr_in),
    .data_in          (data_in),
    .next_proc_addr   (next_proc_addr),
    .next_proc_data   (next_proc_data),
    .rw_halt_in       (rw_halt_in),
    .ext_cpu_q        (ext_cpu_q),
    .ext_cpu_index    (ext_cpu_index),
    .addr_out         (addr_out),
    .data_out         (data_out),
    .read_dn          (read_dn),
    .write_dn         (write_dn),
    .bus_busy         (bus_busy),
    .rw_halt_out      (rw_halt_out),
    .ext_bus_q        (ext_bus_q),
    .ext_bus_allow    (ext_bus_allow),
    .ext_read_dn      (ext_read_dn),
    .ext_write_dn     (ext_write_dn),
    .ext_rw_halt_in   (ext_rw_halt_in),
    .ext_mem_addr_in  (ext_mem_addr_in),
    .ext_mem_data_in  (ext_mem_data_in),
    .ext_read_q       (ext_read_q),
    .ext_write_q      (ext_write_q),
    .ext_mem_addr_out (ext_mem_addr_out),
    .ext_mem_data_out (ext_mem_data_out),
    .ext_rw_halt_out  (ext_rw_halt_out)
  );

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYC) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYC);
    $display("sim failed");
    $fatal(1, "run stopped on timeout");
  end

  // memory reply words derived from the request
  function automatic addr_t reply_addr(input addr_t a);
    reply_addr = a ^ 32'h5a5a_0000;
  endfunction

  function automatic data_t reply_data(input logic is_rd, input addr_t a, input data_t d);
    reply_data = is_rd ? {a[15:0], a[31:16]} : ~d;
  endfunction

  // answers a request strobe after 0 to 3 cycles
  always begin : mem_model
    logic  is_rd;
    addr_t req_addr;
    data_t req_data;
    int    lag;
    @(posedge clk);
    #5;
    if ((ext_read_q || ext_write_q) && !mem_hold) begin
      is_rd    = ext_read_q;
      req_addr = ext_mem_addr_out;
      req_data = ext_mem_data_out;
      lag      = $unsigned($random(seed)) % 4;
      repeat (lag) begin
        @(posedge clk);
        #5;
      end
      ext_read_dn     = is_rd;
      ext_write_dn    = !is_rd;
      ext_mem_addr_in = reply_addr(req_addr);
      ext_mem_data_in = reply_data(is_rd, req_addr, req_data);
      @(posedge clk);
      #5;
      ext_read_dn     = 1'b0;
      ext_write_dn    = 1'b0;
      ext_mem_addr_in = '0;
      ext_mem_data_in = '0;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_index(input string name, input cpu_index_t got, input cpu_index_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // inputs change and outputs are read 5 ns after the edge
  task automatic next_cycle;
    @(posedge clk);
    #5;
  endtask

  // one bounded wait step
  task automatic wait_one_cycle(inout int waited, input int limit, input string what);
    if (waited >= limit) begin
      abort_run(what);
    end else begin
      waited++;
      next_cycle();
    end
  endtask

  // idle cpu first and then round robin over the active ones
  task automatic predict_index(output cpu_index_t idx);
    cpu_num_t np1;
    if (inactive_ref > 0 && !restarted_ref) begin
      idx           = CPU_NONACTIVE;
      restarted_ref = 1'b1;
    end else begin
      np1           = num_ref + cpu_num_t'(1);
      num_ref       = (np1 < active_ref) ? np1 : '0;
      idx           = CPU_ACTIVE | cpu_index_t'(num_ref);
      restarted_ref = 1'b0;
    end
  endtask

  task automatic check_idle_outputs;
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    check_bit("read_dn", read_dn, 1'b0);
    check_bit("write_dn", write_dn, 1'b0);
    check_bit("bus_busy", bus_busy, 1'b0);
    check_bit("ext_bus_allow", ext_bus_allow, 1'b0);
    check_bit("ext_read_q", ext_read_q, 1'b0);
    check_bit("ext_write_q", ext_write_q, 1'b0);
    check_bit("rw_halt_out", rw_halt_out, 1'b0);
    check_bit("ext_rw_halt_out", ext_rw_halt_out, 1'b0);
    check_index("ext_cpu_index", ext_cpu_index, '0);
    check_addr("addr_out", addr_out, '0);
    check_data("data_out", data_out, '0);
    check_addr("ext_mem_addr_out", ext_mem_addr_out, '0);
    check_data("ext_mem_data_out", ext_mem_data_out, '0);
  endtask

  // releases the stall and checks the next dispatch strobe
  task automatic expect_dispatch;
    cpu_index_t exp_idx;
    addr_t      pa;
    data_t      pd;
    int         waited;
    pa             = $random(seed);
    pd             = $random(seed);
    next_proc_addr = pa;
    next_proc_data = pd;
    ext_cpu_e      = 1'b0;
    waited         = 0;
    next_cycle();
    while (!ext_cpu_q) begin
      wait_one_cycle(waited, 6, "no ext_cpu_q strobe after the cpu side went idle");
    end
    predict_index(exp_idx);
    check_index("ext_cpu_index", ext_cpu_index, exp_idx);
    check_addr("addr_out", addr_out, pa);
    check_data("data_out", data_out, pd);
    next_cycle();
    // strobe and words last one cycle
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    check_addr("addr_out", addr_out, '0);
  endtask

  // leaves ext_cpu_e high so the loop stalls afterwards
  task automatic send_msg(input cpu_msg_t msg);
    ext_cpu_e  = 1'b1;
    cpu_msg_in = msg;
    next_cycle();
    cpu_msg_in = '0;
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    if (msg == CPU_R_START) begin
      inactive_ref = inactive_ref - cpu_num_t'(1);
      active_ref   = active_ref + cpu_num_t'(1);
      num_ref      = num_ref + cpu_num_t'(1);
    end else if (msg == CPU_R_END) begin
      active_ref   = active_ref - cpu_num_t'(1);
      inactive_ref = inactive_ref + cpu_num_t'(1);
    end
  endtask

  task automatic dispatch_after_reset;
    check_idle_outputs();
    ext_rst_e = 1'b0;
    next_cycle();
    // ext_cpu_e holds the loop still
    check_idle_outputs();
    repeat (4) begin
      expect_dispatch();
      send_msg(OTHER_MSG);
    end
  endtask

  function automatic cpu_msg_t accounting_msg(input int step);
    case (step)
      0, 1, 3, 5, 9: accounting_msg = CPU_R_START;
      4, 7, 8:       accounting_msg = CPU_R_END;
      default:       accounting_msg = OTHER_MSG;
    endcase
  endfunction

  task automatic count_cpu_messages;
    int i;
    for (i = 0; i < 10; i++) begin
      expect_dispatch();
      send_msg(accounting_msg(i));
    end
    // a few more turns to see the final counts
    repeat (4) begin
      expect_dispatch();
      send_msg(OTHER_MSG);
    end
  endtask

  task automatic forward_mem_op(input logic is_rd);
    addr_t a;
    data_t d;
    int    waited;
    expect_dispatch();
    a       = $random(seed);
    d       = $random(seed);
    addr_in = a;
    data_in = d;
    // both high on a read shows read priority
    read_q  = is_rd;
    write_q = 1'b1;
    next_cycle();
    read_q  = 1'b0;
    write_q = 1'b0;
    waited  = 0;
    while (!(is_rd ? ext_read_q : ext_write_q)) begin
      wait_one_cycle(waited, 4, "no external request strobe after a memory request");
    end
    check_bit("ext_read_q", ext_read_q, is_rd);
    check_bit("ext_write_q", ext_write_q, !is_rd);
    check_addr("ext_mem_addr_out", ext_mem_addr_out, a);
    check_data("ext_mem_data_out", ext_mem_data_out, is_rd ? data_t'(0) : d);
    check_bit("bus_busy", bus_busy, 1'b1);
    waited = 0;
    next_cycle();
    while (!(is_rd ? read_dn : write_dn)) begin
      check_bit("ext_read_q", ext_read_q, 1'b0);
      check_bit("ext_write_q", ext_write_q, 1'b0);
      check_bit("bus_busy", bus_busy, 1'b1);
      wait_one_cycle(waited, 10, "no done strobe after the memory answered");
    end
    check_bit("read_dn", read_dn, is_rd);
    check_bit("write_dn", write_dn, !is_rd);
    check_addr("addr_out", addr_out, reply_addr(a));
    check_data("data_out", data_out, reply_data(is_rd, a, d));
    check_bit("bus_busy", bus_busy, 1'b0);
    check_addr("ext_mem_addr_out", ext_mem_addr_out, '0);
    ext_cpu_e = 1'b1;
    next_cycle();
    check_bit("read_dn", read_dn, 1'b0);
    check_bit("write_dn", write_dn, 1'b0);
    check_addr("addr_out", addr_out, '0);
  endtask

  // cpu_side set halts through rw_halt_in, clear through ext_rw_halt_in
  task automatic abort_mem_op(input logic is_rd, input logic cpu_side);
    int waited;
    expect_dispatch();
    mem_hold = 1'b1;
    addr_in  = $random(seed);
    data_in  = $random(seed);
    read_q   = is_rd;
    write_q  = !is_rd;
    next_cycle();
    read_q   = 1'b0;
    write_q  = 1'b0;
    waited   = 0;
    while (!(is_rd ? ext_read_q : ext_write_q)) begin
      wait_one_cycle(waited, 4, "no external request strobe before the halt");
    end
    // keep it pending a little
    repeat (2) begin
      next_cycle();
      check_bit("bus_busy", bus_busy, 1'b1);
    end
    rw_halt_in     = cpu_side;
    ext_rw_halt_in = !cpu_side;
    next_cycle();
    rw_halt_in     = 1'b0;
    ext_rw_halt_in = 1'b0;
    ext_cpu_e      = 1'b1;
    check_bit("ext_rw_halt_out", ext_rw_halt_out, cpu_side);
    check_bit("rw_halt_out", rw_halt_out, !cpu_side);
    // late answer from memory after the abort
    ext_read_dn  = is_rd;
    ext_write_dn = !is_rd;
    // no done strobe after the abort
    repeat (6) begin
      next_cycle();
      ext_read_dn  = 1'b0;
      ext_write_dn = 1'b0;
      check_bit("ext_rw_halt_out", ext_rw_halt_out, 1'b0);
      check_bit("rw_halt_out", rw_halt_out, 1'b0);
      check_bit("read_dn", read_dn, 1'b0);
      check_bit("write_dn", write_dn, 1'b0);
      check_bit("bus_busy", bus_busy, 1'b0);
      check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
      check_addr("ext_mem_addr_out", ext_mem_addr_out, '0);
    end
    mem_hold = 1'b0;
  endtask

  task automatic grant_ext_bus;
    int waited;
    // bus request wins over an idle cpu side
    ext_bus_q = 1'b1;
    ext_cpu_e = 1'b0;
    waited    = 0;
    while (!ext_bus_allow) begin
      check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
      wait_one_cycle(waited, 4, "ext_bus_allow never rose while ext_bus_q was held");
    end
    repeat (8) begin
      next_cycle();
      check_bit("ext_bus_allow", ext_bus_allow, 1'b1);
      check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    end
    ext_bus_q = 1'b0;
    next_cycle();
    check_bit("ext_bus_allow", ext_bus_allow, 1'b0);
    check_bit("ext_cpu_q", ext_cpu_q, 1'b0);
    // dispatch picks up again
    expect_dispatch();
    send_msg(OTHER_MSG);
  endtask

  initial begin
    ext_rst_e       = 1'b1;
    ext_cpu_e       = 1'b1;
    read_q          = 1'b0;
    write_q         = 1'b0;
    ext_bus_q       = 1'b0;
    cpu_msg_in      = '0;
    addr_in         = '0;
    data_in         = '0;
    next_proc_addr  = '0;
    next_proc_data  = '0;
    rw_halt_in      = 1'b0;
    ext_read_dn     = 1'b0;
    ext_write_dn    = 1'b0;
    ext_rw_halt_in  = 1'b0;
    ext_mem_addr_in = '0;
    ext_mem_data_in = '0;
    mem_hold        = 1'b0;
    active_ref      = '0;
    inactive_ref    = cpu_num_t'(CPU_QUANTITY);
    num_ref         = '0;
    restarted_ref   = 1'b0;
    repeat (16) @(posedge clk);
    #5;
    dispatch_after_reset();
    count_cpu_messages();
    forward_mem_op(1'b1);
    forward_mem_op(1'b0);
    abort_mem_op(1'b1, 1'b1);
    abort_mem_op(1'b0, 1'b0);
    grant_ext_bus();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_dispatcher.f */
source/dispatch_cfg_pkg.sv
source/dispatch_proto_pkg.sv
source/mem_req_if.sv
source/cpu_scheduler.sv
source/mem_bridge.sv
source/cpu_dispatcher.sv
testbench/tb_cpu_dispatcher.sv

/* Bender.yml */
package:
  name: cpu_dispatcher

sources:
  # packages first, then interface, leaves and top
  - files:
      - source/dispatch_cfg_pkg.sv
      - source/dispatch_proto_pkg.sv
      - source/mem_req_if.sv
      - source/cpu_scheduler.sv
      - source/mem_bridge.sv
      - source/cpu_dispatcher.sv

  - target: test
    files:
      - testbench/tb_cpu_dispatcher.sv
